// File: Makefile
# Verilator build and run for the address unit

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_addr_unit
FILELIST  = addr_unit.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; \
	echo "$$out"; \
	[ $$status -eq 0 ] && echo "$$out" | grep -qFx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: addr_unit.f
verilog/addr_pkg.sv
verilog/addr_ctl_decode.sv
verilog/inc_dec.sv
verilog/ir_register.sv
verilog/address_latch.sv
verilog/addr_unit.sv
tests/tb_addr_unit.sv

// File: tests/tb_addr_unit.sv
// Directed testbench for the address unit with a reference model and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_addr_unit;

    localparam int ADDR_W          = 16;
    localparam int CLK_PERIOD      = 10;            // ns
    localparam int RESET_CYCLES    = 10;
    localparam logic [31:0] LFSR_SEED = 32'd94105;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;   // x^32+x^22+x^2+x+1
    // Reset 10, reset state 14, inc/dec 37, latch 3, bus 4, refresh 51, mixed 200
    localparam int TEST_CYCLES     = 10 + 14 + 37 + 3 + 4 + 51 + 200;
    localparam int WATCHDOG_MARGIN = 200;

    // --------------------
    // DUT signals
    // --------------------
    logic               clk;
    logic               reset;
    addr_pkg::addr_op_e op;
    logic [ADDR_W-1:0]  dbus_in;
    logic [ADDR_W-1:0]  dbus_out;
    logic               dbus_oe;
    logic [ADDR_W-1:0]  address;
    logic               address_is_1;
    logic [ADDR_W-1:0]  ir_value;

    logic [ADDR_W-1:0]  model_latch;                // Expected latch contents
    logic [ADDR_W-1:0]  model_ir;                   // Expected I/R contents
    logic [31:0]        lfsr;                       // Random source state

    addr_unit #(
        .ADDR_W (ADDR_W)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .op           (op),
        .dbus_in      (dbus_in),
        .dbus_out     (dbus_out),
        .dbus_oe      (dbus_oe),
        .address      (address),
        .address_is_1 (address_is_1),
        .ir_value     (ir_value)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    // Galois LFSR stepped once per bit handed out
    function automatic logic [ADDR_W-1:0] rand_bits(input int n);
        logic [ADDR_W-1:0] v;
        logic              b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ LFSR_TAPS;
            end
            v = {v[ADDR_W-2:0], b};
        end
        return v;
    endfunction

    // Step by one; limited mode only counts bits 6..0
    function automatic logic [ADDR_W-1:0] model_step(input logic [ADDR_W-1:0] v,
                                                     input logic dec, input logic limit);
        logic [6:0] low;
        if (limit) begin
            low = dec ? (v[6:0] - 7'd1) : (v[6:0] + 7'd1);
            return {v[ADDR_W-1:7], low};
        end
        return dec ? (v - ADDR_W'(1)) : (v + ADDR_W'(1));
    endfunction

    task automatic check(input string name, input logic [ADDR_W-1:0] actual,
                         input logic [ADDR_W-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Compare all outputs with the model, then commit the model writes
    task automatic compare_model(input addr_pkg::addr_op_e o, input logic [ADDR_W-1:0] d);
        logic [ADDR_W-1:0] exp_addr;
        logic [ADDR_W-1:0] exp_out;
        logic              exp_oe;
        logic [ADDR_W-1:0] next_latch;
        logic [ADDR_W-1:0] next_ir;
        exp_addr   = model_latch;                   // Latch drives unless stated
        exp_out    = '0;
        exp_oe     = 1'b0;
        next_latch = model_latch;
        next_ir    = model_ir;
        case (o)
            addr_pkg::OP_PASS:      exp_addr = d;
            addr_pkg::OP_INC:       exp_addr = model_step(d, 1'b0, 1'b0);
            addr_pkg::OP_DEC:       exp_addr = model_step(d, 1'b1, 1'b0);
            addr_pkg::OP_AL_LOAD: begin
                exp_addr   = d;
                next_latch = d;
            end
            addr_pkg::OP_BUS_WRITE: begin
                exp_oe  = 1'b1;
                exp_out = model_latch;
            end
            addr_pkg::OP_BUS_ZERO: begin
                exp_oe   = 1'b1;
                exp_addr = '0;
            end
            addr_pkg::OP_IR_LOAD:   next_ir = d;
            addr_pkg::OP_IR_INC: begin
                exp_addr = model_step(model_ir, 1'b0, 1'b1);
                next_ir  = exp_addr;
            end
            default: begin
            end                                     // Idle and bad encodings
        endcase
        check("address", address, exp_addr);
        check("address_is_1", ADDR_W'(address_is_1), ADDR_W'(exp_addr == ADDR_W'(1)));
        check("dbus_out", dbus_out, exp_out);
        check("dbus_oe", ADDR_W'(dbus_oe), ADDR_W'(exp_oe));
        check("ir_value", ir_value, model_ir);
        model_latch = next_latch;
        model_ir    = next_ir;
    endtask

    // One op per cycle with outputs sampled mid-cycle
    task automatic apply_op(input addr_pkg::addr_op_e o, input logic [ADDR_W-1:0] d);
        @(posedge clk);
        op      <= o;
        dbus_in <= d;
        @(negedge clk);
        compare_model(o, d);
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic reset_state();
        apply_op(addr_pkg::OP_AL_LOAD, 16'hA5C3);  // Dirty state for reset to clear
        apply_op(addr_pkg::OP_IR_LOAD, 16'h5C3A);
        @(posedge clk);
        reset <= 1'b1;
        op    <= addr_pkg::OP_IDLE;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        model_latch = '0;
        model_ir    = '0;
        apply_op(addr_pkg::OP_IDLE, '0);
        check("address", address, 16'h0000);
        check("dbus_oe", ADDR_W'(dbus_oe), '0);
        check("ir_value", ir_value, 16'h0000);
        check("address_is_1", ADDR_W'(address_is_1), '0);
    endtask

    task automatic inc_dec_wrap();
        logic [ADDR_W-1:0] d;
        apply_op(addr_pkg::OP_INC, 16'h0000);
        check("address", address, 16'h0001);
        check("address_is_1", ADDR_W'(address_is_1), ADDR_W'(1));
        apply_op(addr_pkg::OP_DEC, 16'h0000);
        check("address", address, 16'hFFFF);       // Wraps down
        apply_op(addr_pkg::OP_INC, 16'hFFFF);
        check("address", address, 16'h0000);       // Wraps up
        apply_op(addr_pkg::OP_DEC, 16'hFFFF);
        check("address", address, 16'hFFFE);
        apply_op(addr_pkg::OP_PASS, 16'h1234);
        check("address", address, 16'h1234);
        for (int i = 0; i < 32; i++) begin
            d = rand_bits(ADDR_W);
            case (i % 3)
                0:       apply_op(addr_pkg::OP_INC, d);
                1:       apply_op(addr_pkg::OP_DEC, d);
                default: apply_op(addr_pkg::OP_PASS, d);
            endcase
        end
    endtask

    task automatic latch_and_mux();
        apply_op(addr_pkg::OP_AL_LOAD, 16'hAA55);
        check("address", address, 16'hAA55);       // Pass-through while loading
        apply_op(addr_pkg::OP_PASS, 16'hCAFE);
        check("address", address, 16'hCAFE);
        apply_op(addr_pkg::OP_IDLE, 16'h0000);
        check("address", address, 16'hAA55);       // Now from the latch
    endtask

    task automatic bus_write_and_zero();
        apply_op(addr_pkg::OP_AL_LOAD, 16'h5A3C);
        apply_op(addr_pkg::OP_BUS_WRITE, 16'h1111);
        check("dbus_oe", ADDR_W'(dbus_oe), ADDR_W'(1));
        check("dbus_out", dbus_out, 16'h5A3C);
        apply_op(addr_pkg::OP_IDLE, 16'h0000);
        check("dbus_oe", ADDR_W'(dbus_oe), '0);
        apply_op(addr_pkg::OP_BUS_ZERO, 16'hFFFF);
        check("dbus_out", dbus_out, 16'h0000);
        check("address", address, 16'h0000);
    endtask

    task automatic refresh_counter();
        apply_op(addr_pkg::OP_IR_LOAD, 16'h3A7F);
        apply_op(addr_pkg::OP_IR_INC, 16'h0000);
        check("address", address, 16'h3A00);       // R[6:0] wrapped, R[7] kept
        apply_op(addr_pkg::OP_IDLE, 16'h0000);
        check("ir_value", ir_value, 16'h3A00);
        for (int i = 0; i < 8; i++) begin
            apply_op(addr_pkg::OP_IR_LOAD, rand_bits(ADDR_W));
            repeat (5) begin
                apply_op(addr_pkg::OP_IR_INC, rand_bits(ADDR_W));
            end
        end
    endtask

    task automatic mixed_sequence();
        logic [ADDR_W-1:0] o_bits;
        for (int i = 0; i < 200; i++) begin
            o_bits = rand_bits(4);                  // Includes bad encodings
            apply_op(addr_pkg::addr_op_e'(o_bits[3:0]), rand_bits(ADDR_W));
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        op          = addr_pkg::OP_IDLE;
        dbus_in     = '0;
        model_latch = '0;
        model_ir    = '0;
        lfsr        = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        reset_state();
        inc_dec_wrap();
        latch_and_mux();
        bus_write_and_zero();
        refresh_counter();
        mixed_sequence();
        $display("Done: no errors");
        $finish;
    end

    // Watchdog sized from the test cycle count
    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + WATCHDOG_MARGIN));
        $display("Timeout: the tests ran longer than their expected cycle count");
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// File: verilog/addr_ctl_decode.sv
// Opcode decoder that expands an address operation into control strobes
`timescale 1ns/1ps
`default_nettype none

module addr_ctl_decode (
    input  addr_pkg::addr_op_e  op,     // Operation for this cycle
    output addr_pkg::addr_ctl_t ctl     // Strobes to latch and I/R
);

    always_comb begin
        ctl = addr_pkg::CTL_IDLE;               // Everything off by default

        case (op)
            // --------------------
            // Plain address ops
            // --------------------
            addr_pkg::OP_IDLE: begin
                ctl = addr_pkg::CTL_IDLE;       // Latch drives the address
            end
            addr_pkg::OP_PASS: begin
                ctl.ab_mux_inc = 1'b1;          // Incrementer with no carry
            end
            addr_pkg::OP_INC: begin
                ctl.ab_mux_inc = 1'b1;
                ctl.inc_cy     = 1'b1;          // Plus one
            end
            addr_pkg::OP_DEC: begin
                ctl.ab_mux_inc = 1'b1;
                ctl.inc_cy     = 1'b1;
                ctl.inc_dec    = 1'b1;          // Minus one
            end

            // --------------------
            // Latch and bus
            // --------------------
            addr_pkg::OP_AL_LOAD: begin
                ctl.al_we      = 1'b1;          // Capture data bus
                ctl.ab_mux_inc = 1'b1;          // Show pass-through meanwhile
            end
            addr_pkg::OP_BUS_WRITE: begin
                ctl.bus_inc_we = 1'b1;          // Latch value onto bus
            end
            addr_pkg::OP_BUS_ZERO: begin
                ctl.bus_inc_we = 1'b1;
                ctl.inc_zero   = 1'b1;          // Zero on bus
                ctl.ab_mux_inc = 1'b1;          // and zero on the address
            end

            // --------------------
            // I/R pair
            // --------------------
            addr_pkg::OP_IR_LOAD: begin
                ctl.ir_we = 1'b1;               // Source stays data bus
            end
            addr_pkg::OP_IR_INC: begin
                ctl.inc_src_ir = 1'b1;          // Feed I/R to incrementer
                ctl.inc_cy     = 1'b1;
                ctl.inc_limit6 = 1'b1;          // Only R[6:0] counts
                ctl.ab_mux_inc = 1'b1;          // Refresh address out
                ctl.ir_we      = 1'b1;          // Write the stepped value back
            end

            // Corrupt encoding never writes state
            default: begin
                ctl = addr_pkg::CTL_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/addr_pkg.sv
// Shared opcode and control strobe types for the address path
`default_nettype none

package addr_pkg;

    // --------------------
    // Per-cycle address operation
    // --------------------
    typedef enum logic [3:0] {
        OP_IDLE      = 4'd0,    // Address from latch, no writes
        OP_PASS      = 4'd1,    // Data bus straight through incrementer
        OP_INC       = 4'd2,    // Data bus plus one
        OP_DEC       = 4'd3,    // Data bus minus one
        OP_AL_LOAD   = 4'd4,    // Latch takes data bus
        OP_BUS_WRITE = 4'd5,    // Latch value onto data bus
        OP_BUS_ZERO  = 4'd6,    // Zero onto data bus and address
        OP_IR_LOAD   = 4'd7,    // I/R pair takes data bus
        OP_IR_INC    = 4'd8     // Refresh step on R, limited carry
    } addr_op_e;

    // --------------------
    // Control strobes, one set per cycle
    // --------------------
    typedef struct packed {
        logic ab_mux_inc;       // Address from incrementer, else latch
        logic al_we;            // Address latch write enable
        logic bus_inc_we;       // Drive the data bus
        logic inc_dec;          // Decrement instead of increment
        logic inc_limit6;       // Carry stops above bit 6
        logic inc_cy;           // Carry-in of one
        logic inc_zero;         // Incrementer outputs zero
        logic ir_we;            // I/R write enable
        logic inc_src_ir;       // Incrementer source is I/R, else data bus
    } addr_ctl_t;

    // All strobes low for idle and for bad opcodes
    localparam addr_ctl_t CTL_IDLE = '{
        ab_mux_inc: 1'b0,
        al_we:      1'b0,
        bus_inc_we: 1'b0,
        inc_dec:    1'b0,
        inc_limit6: 1'b0,
        inc_cy:     1'b0,
        inc_zero:   1'b0,
        ir_we:      1'b0,
        inc_src_ir: 1'b0
    };

endpackage

`default_nettype wire

// File: verilog/addr_unit.sv
// Address unit top level joining decoder, address latch and I/R register
`timescale 1ns/1ps
`default_nettype none

module addr_unit #(
    parameter int ADDR_W = 16                   // Address width for all blocks
) (
    input  logic                clk,
    input  logic                reset,          // Sync, active high
    input  addr_pkg::addr_op_e  op,             // Operation this cycle
    input  logic [ADDR_W-1:0]   dbus_in,        // Internal data bus in
    output logic [ADDR_W-1:0]   dbus_out,       // Internal data bus out
    output logic                dbus_oe,        // Bus drive enable
    output logic [ADDR_W-1:0]   address,        // External address bus
    output logic                address_is_1,   // Address equals one
    output logic [ADDR_W-1:0]   ir_value        // I/R pair contents
);

    // --------------------
    // Internal wires
    // --------------------
    addr_pkg::addr_ctl_t ctl;                   // Decoded strobes
    logic [ADDR_W-1:0]   inc_result;            // Incrementer back to I/R

    addr_ctl_decode u_decode (
        .op  (op),
        .ctl (ctl)
    );

    address_latch #(
        .ADDR_W (ADDR_W)
    ) u_address_latch (
        .clk          (clk),
        .reset        (reset),
        .ctl          (ctl),
        .dbus_in      (dbus_in),
        .ir_value     (ir_value),
        .inc_result   (inc_result),
        .address      (address),
        .address_is_1 (address_is_1),
        .dbus_out     (dbus_out),
        .dbus_oe      (dbus_oe)
    );

    ir_register #(
        .ADDR_W (ADDR_W)
    ) u_ir_register (
        .clk        (clk),
        .reset      (reset),
        .ctl        (ctl),
        .dbus_in    (dbus_in),
        .inc_result (inc_result),
        .ir_value   (ir_value)
    );

endmodule

`default_nettype wire

// File: verilog/address_latch.sv
// Address latch with incrementer, address bus mux and internal data bus driver
`timescale 1ns/1ps
`default_nettype none

module address_latch #(
    parameter int ADDR_W = 16                   // Address width
) (
    input  logic                clk,
    input  logic                reset,          // Sync, active high
    input  addr_pkg::addr_ctl_t ctl,            // Per-cycle strobes
    input  logic [ADDR_W-1:0]   dbus_in,        // Internal data bus in
    input  logic [ADDR_W-1:0]   ir_value,       // I/R pair for refresh
    output logic [ADDR_W-1:0]   inc_result,     // Incrementer out, to I/R
    output logic [ADDR_W-1:0]   address,        // External address bus
    output logic                address_is_1,   // Address equals one
    output logic [ADDR_W-1:0]   dbus_out,       // Internal data bus out
    output logic                dbus_oe         // Bus drive enable
);

    // --------------------
    // Latch register
    // --------------------
    logic [ADDR_W-1:0] latch_q;                 // Held address

    always_ff @(posedge clk) begin
        if (reset) begin
            latch_q <= '0;
        end else if (ctl.al_we) begin
            latch_q <= dbus_in;                 // Capture from data bus
        end
    end

    // --------------------
    // Incrementer
    // --------------------
    logic [ADDR_W-1:0] inc_src;                 // Incrementer input

    always_comb begin
        if (ctl.inc_src_ir) begin
            inc_src = ir_value;                 // Refresh cycle
        end else begin
            inc_src = dbus_in;                  // Normal address step
        end
    end

    inc_dec #(
        .ADDR_W (ADDR_W)
    ) u_inc_dec (
        .din  (inc_src),
        .ctl  (ctl),
        .dout (inc_result)
    );

    // --------------------
    // Address bus mux
    // --------------------
    always_comb begin
        if (ctl.ab_mux_inc) begin
            address = inc_result;               // Stepped or passed value
        end else begin
            address = latch_q;                  // Held address
        end
    end

    // Status flag for loop counting
    assign address_is_1 = (address == {{(ADDR_W-1){1'b0}}, 1'b1});

    // --------------------
    // Data bus driver
    // --------------------
    // Split from the tri-state bus, so idle drives zero
    always_comb begin
        dbus_oe  = ctl.bus_inc_we;
        dbus_out = '0;
        if (ctl.bus_inc_we) begin
            if (ctl.inc_zero) begin
                dbus_out = '0;                  // Force-zero onto bus
            end else begin
                dbus_out = latch_q;             // Latched value onto bus
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/inc_dec.sv
// Shared incrementer and decrementer with limited-carry and force-zero modes
`timescale 1ns/1ps
`default_nettype none

module inc_dec #(
    parameter int ADDR_W = 16           // Word width, 8 or more
) (
    input  logic [ADDR_W-1:0]   din,    // Value to step
    input  addr_pkg::addr_ctl_t ctl,    // Uses inc_dec/limit6/cy/zero
    output logic [ADDR_W-1:0]   dout    // Stepped value
);

    localparam int LOW_W = 7;           // Limited carry covers bits 6..0

    // --------------------
    // Carry-in vectors
    // --------------------
    logic [ADDR_W-1:0] step_full;       // Carry-in at full width
    logic [LOW_W-1:0]  step_low;        // Carry-in at seven bits

    assign step_full = {{(ADDR_W-1){1'b0}}, ctl.inc_cy};
    assign step_low  = {{(LOW_W-1){1'b0}}, ctl.inc_cy};

    // --------------------
    // Arithmetic
    // --------------------
    logic [ADDR_W-1:0] full_res;        // Wraps modulo 2^ADDR_W
    logic [LOW_W-1:0]  low_res;         // Wraps inside the low seven bits
    logic [ADDR_W-1:0] limit_res;       // Upper part kept as is

    always_comb begin
        if (ctl.inc_dec) begin
            full_res = din - step_full;
            low_res  = din[LOW_W-1:0] - step_low;
        end else begin
            full_res = din + step_full;
            low_res  = din[LOW_W-1:0] + step_low;
        end
    end

    // Splice the counted bits under the untouched upper part
    assign limit_res = {din[ADDR_W-1:LOW_W], low_res};

    // --------------------
    // Output select
    // --------------------
    always_comb begin
        if (ctl.inc_limit6) begin
            dout = limit_res;           // Refresh counter mode
        end else begin
            dout = full_res;            // Normal address step or pass
        end

        if (ctl.inc_zero) begin
            dout = '0;                  // Force-zero wins over everything
        end
    end

endmodule

`default_nettype wire

// File: verilog/ir_register.sv
// I/R register pair holding the interrupt page and the memory refresh counter
`timescale 1ns/1ps
`default_nettype none

module ir_register #(
    parameter int ADDR_W = 16                   // I in upper bits, R in low byte
) (
    input  logic                clk,
    input  logic                reset,          // Sync, active high
    input  addr_pkg::addr_ctl_t ctl,            // Uses ir_we and inc_src_ir
    input  logic [ADDR_W-1:0]   dbus_in,        // Load value
    input  logic [ADDR_W-1:0]   inc_result,     // Refresh step from incrementer
    output logic [ADDR_W-1:0]   ir_value        // Current I/R contents
);

    // --------------------
    // Next value select
    // --------------------
    logic [ADDR_W-1:0] ir_next;                 // Value written on ir_we
    logic [ADDR_W-1:0] ir_q;                    // The register itself

    // Refresh step comes back through the shared incrementer,
    // so only R[6:0] moves and R[7] plus I hold
    always_comb begin
        if (ctl.inc_src_ir) begin
            ir_next = inc_result;               // Increment case
        end else begin
            ir_next = dbus_in;                  // Load case
        end
    end

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ir_q <= '0;                         // I and R both clear
        end else if (ctl.ir_we) begin
            ir_q <= ir_next;                    // Visible next cycle
        end
    end

    assign ir_value = ir_q;

endmodule

`default_nettype wire
